// File: uart_consts.svh
// UART peripheral constants
// Bus and byte widths, base address and register word offsets
// CTRL write mask, frame bit counts and reset values
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// Peripheral bus widths
`define UART_ADDR_W     14
`define UART_DATA_W     16
`define UART_BYTE_W     8

// Byte base address, aligned to 8 bytes
`define UART_BASE_ADDR  15'h0080

// Word offsets inside the 8-byte window
// CTRL low and STATUS high
`define UART_WORD_CTRL  2'd0
// BAUD_LO low and BAUD_HI high
`define UART_WORD_BAUD  2'd1
// DATA_TX low and DATA_RX high
`define UART_WORD_DATA  2'd2

// Writable CTRL bits: ien_tx, ien_rx_ovflw, ien_rx, en
`define UART_CTRL_MASK  8'h71

// Last bit-counter value of a frame
`define UART_RX_BITS    4'd10
`define UART_TX_BITS    4'd11

// Reset values
`define UART_CTRL_RST   8'h00
`define UART_BAUD_RST   16'h0000
`define UART_DATA_RST   8'h00
`define UART_RXD_IDLE   1'b1
`define UART_TX_IDLE    9'h1ff

`endif

// File: uart_pkg.sv
// UART shared types
// CTRL and STATUS register layouts, baud divisor, filter history
`default_nettype none

`include "uart_consts.svh"

package uart_pkg;

  // CTRL register, bit 7 down to bit 0
  typedef struct packed {
    logic       unused1;
    logic       ien_tx;
    logic       ien_rx_ovflw;
    logic       ien_rx;
    logic [2:0] unused2;
    logic       en;
  } ctrl_t;

  // STATUS register, sticky flags in the upper nibble
  typedef struct packed {
    logic tx_empty_pnd;
    logic tx_pnd;
    logic rx_ovflw_pnd;
    logic rx_pnd;
    logic tx_full;
    logic tx_busy;
    logic zero;
    logic rx_busy;
  } status_t;

  // Bit period minus one, in mclk cycles
  typedef logic [`UART_DATA_W-1:0] baud_t;

  // Two past samples of the synchronized RXD line
  typedef logic [1:0] rx_hist_t;

endpackage

`default_nettype wire

// File: uart_ctl_if.sv
// Control and status link between the register block and the engines
// Modports regs, rx and tx
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

interface uart_ctl_if import uart_pkg::*; ();

  // From the register block
  logic                    en;
  baud_t                   baud;
  logic [`UART_BYTE_W-1:0] tx_data;
  logic                    tx_load;

  // From the transmit engine
  logic                    tx_done;
  logic                    tx_idle_done;
  logic                    tx_busy;
  logic                    tx_full;

  // From the receive engine
  logic [`UART_BYTE_W-1:0] rx_data;
  logic                    rx_done;
  logic                    rx_busy;

  modport regs (
    output en, baud, tx_data, tx_load,
    input  tx_done, tx_idle_done, tx_busy, tx_full,
    input  rx_data, rx_done, rx_busy
  );

  modport rx (input en, baud, output rx_data, rx_done, rx_busy);

  modport tx (
    input  en, baud, tx_data, tx_load,
    output tx_done, tx_idle_done, tx_busy, tx_full
  );

endinterface

`default_nettype wire

// File: uart_rx_filter.sv
// RXD front end
// Two-flop synchronizer, three-sample majority filter, falling-edge flag
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_rx_filter import uart_pkg::*; (
  input  logic mclk,
  input  logic puc_rst,
  input  logic uart_rxd,
  output logic rxd_s,
  output logic rxd_fe
);

  logic [1:0] rxd_sync;
  rx_hist_t   rxd_hist;
  logic       rxd_maj;
  logic       rxd_maj_nxt;

  // Sync stages, line idles high
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) rxd_sync <= {2{`UART_RXD_IDLE}};
    else         rxd_sync <= {rxd_sync[0], uart_rxd};
  end

  // Sample history for the filter
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) rxd_hist <= {2{`UART_RXD_IDLE}};
    else         rxd_hist <= {rxd_hist[0], rxd_sync[1]};
  end

  // Two out of three votes
  assign rxd_maj_nxt = (rxd_sync[1] & rxd_hist[0]) |
                       (rxd_sync[1] & rxd_hist[1]) |
                       (rxd_hist[0] & rxd_hist[1]);

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) rxd_maj <= `UART_RXD_IDLE;
    else         rxd_maj <= rxd_maj_nxt;
  end

  assign rxd_s  = rxd_maj;
  // Filtered line about to fall
  assign rxd_fe = rxd_maj & ~rxd_maj_nxt;

endmodule

`default_nettype wire

// File: uart_rx.sv
// UART receive engine
// Frame bit counter, bit-period down-counter and receive shift register
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_rx import uart_pkg::*; (
  input  logic   mclk,
  input  logic   puc_rst,
  input  logic   rxd_s,
  input  logic   rxd_fe,
  uart_ctl_if.rx ctl
);

  logic [3:0]              rx_bit;
  baud_t                   rx_cnt;
  logic [`UART_BYTE_W-1:0] rx_buf;
  logic                    rx_start;
  logic                    rx_step;
  logic                    rx_last;

  // ====================================================================
  // Frame sequencing
  // ====================================================================

  // Start edge only while idle
  assign rx_start = (rx_bit == 4'd0) & rxd_fe;
  // Bit step when the period counter runs out
  assign rx_step  = (rx_bit != 4'd0) & (rx_cnt == '0);
  assign rx_last  = (rx_bit == `UART_RX_BITS);

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      rx_bit <= 4'd0;
    end else if (!ctl.en) begin
      rx_bit <= 4'd0;
    end else if (rx_start) begin
      rx_bit <= 4'd1;
    end else if (rx_last) begin
      rx_bit <= 4'd0;
    end else if (rx_step) begin
      rx_bit <= rx_bit + 4'd1;
    end
  end

  // Half period to reach mid start bit, full period after that
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      rx_cnt <= '0;
    end else if (!ctl.en) begin
      rx_cnt <= '0;
    end else if (rx_start) begin
      rx_cnt <= ctl.baud >> 1;
    end else if (rx_step) begin
      rx_cnt <= ctl.baud;
    end else if (rx_cnt != '0) begin
      rx_cnt <= rx_cnt - baud_t'(1);
    end
  end

  // ====================================================================
  // Data capture
  // ====================================================================

  // LSB first, start bit drops out at the bottom
  always_ff @(posedge mclk) begin
    if (rx_step) rx_buf <= {rxd_s, rx_buf[`UART_BYTE_W-1:1]};
  end

  assign ctl.rx_data = rx_buf;
  assign ctl.rx_done = rx_last;
  assign ctl.rx_busy = (rx_bit != 4'd0);

endmodule

`default_nettype wire

// File: uart_tx.sv
// UART transmit engine
// One-deep trigger, frame bit counter, bit-period counter, shift register
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_tx import uart_pkg::*; (
  input  logic   mclk,
  input  logic   puc_rst,
  output logic   uart_txd,
  uart_ctl_if.tx ctl
);

  logic                    tx_trig;
  logic [3:0]              tx_bit;
  baud_t                   tx_cnt;
  logic [`UART_BYTE_W:0]   tx_buf;
  logic                    tx_start;
  logic                    tx_step;
  logic                    tx_last;
  logic                    tx_active;

  // ====================================================================
  // Trigger and frame sequencing
  // ====================================================================

  assign tx_active = (tx_bit != 4'd0);
  // Pending byte waits for an idle, enabled engine
  assign tx_start  = ctl.en & ~tx_active & tx_trig;
  assign tx_step   = tx_active & (tx_cnt == '0);
  assign tx_last   = (tx_bit == `UART_TX_BITS);

  // New write wins over consumption
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst)           tx_trig <= 1'b0;
    else if (ctl.tx_load)  tx_trig <= 1'b1;
    else if (tx_start)     tx_trig <= 1'b0;
  end

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      tx_bit <= 4'd0;
    end else if (!ctl.en) begin
      tx_bit <= 4'd0;
    end else if (tx_start) begin
      tx_bit <= 4'd1;
    end else if (tx_last) begin
      tx_bit <= 4'd0;
    end else if (tx_step) begin
      tx_bit <= tx_bit + 4'd1;
    end
  end

  // Full bit period per step
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      tx_cnt <= '0;
    end else if (!ctl.en) begin
      tx_cnt <= '0;
    end else if (tx_start || tx_step) begin
      tx_cnt <= ctl.baud;
    end else if (tx_cnt != '0) begin
      tx_cnt <= tx_cnt - baud_t'(1);
    end
  end

  // ====================================================================
  // Serial output
  // ====================================================================

  // Start bit at the bottom, ones shifted in behind the data
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      tx_buf <= `UART_TX_IDLE;
    end else if (!ctl.en) begin
      tx_buf <= `UART_TX_IDLE;
    end else if (tx_start) begin
      tx_buf <= {ctl.tx_data, 1'b0};
    end else if (tx_step) begin
      tx_buf <= {1'b1, tx_buf[`UART_BYTE_W:1]};
    end
  end

  assign uart_txd = tx_buf[0];

  // Status towards the register block
  assign ctl.tx_done      = tx_last;
  assign ctl.tx_idle_done = tx_last & ~tx_trig;
  assign ctl.tx_busy      = tx_active | tx_trig;
  assign ctl.tx_full      = tx_active & tx_trig;

endmodule

`default_nettype wire

// File: uart_regs.sv
// UART register block
// Address decode, CTRL, BAUD, DATA_TX and DATA_RX registers
// Sticky pending flags, STATUS assembly, read mux and interrupts
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_regs import uart_pkg::*; (
  input  logic                    mclk,
  input  logic                    puc_rst,
  input  logic [`UART_ADDR_W-1:0] per_addr,
  input  logic [`UART_DATA_W-1:0] per_din,
  input  logic                    per_en,
  input  logic [1:0]              per_we,
  output logic [`UART_DATA_W-1:0] per_dout,
  uart_ctl_if.regs                ctl,
  output logic                    irq_uart_rx,
  output logic                    irq_uart_tx
);

  localparam logic [`UART_ADDR_W:0] base_addr = `UART_BASE_ADDR;

  // Pending flag positions, same order as STATUS[7:4]
  localparam int pnd_rx       = 0;
  localparam int pnd_rx_ovflw = 1;
  localparam int pnd_tx       = 2;
  localparam int pnd_tx_empty = 3;

  logic                    reg_sel;
  logic [1:0]              reg_word;
  logic                    wr_lo;
  logic                    wr_hi;
  logic                    reg_rd;
  logic                    ctrl_wr;
  logic                    status_wr;
  logic                    baud_lo_wr;
  logic                    baud_hi_wr;
  logic                    data_tx_wr;
  ctrl_t                   ctrl;
  status_t                 status;
  baud_t                   baud;
  logic [`UART_BYTE_W-1:0] data_tx;
  logic [`UART_BYTE_W-1:0] data_rx;
  logic [3:0]              pnd;
  logic [3:0]              pnd_set;
  logic [3:0]              pnd_clr;

  // ====================================================================
  // Decode
  // ====================================================================

  // 8-byte window, word index in the two low bits
  assign reg_sel  = per_en &
                    (per_addr[`UART_ADDR_W-1:2] == base_addr[`UART_ADDR_W:3]);
  assign reg_word = per_addr[1:0];

  assign wr_lo  = reg_sel & per_we[0];
  assign wr_hi  = reg_sel & per_we[1];
  assign reg_rd = reg_sel & ~|per_we;

  // Byte lane strobes per register
  assign ctrl_wr    = wr_lo & (reg_word == `UART_WORD_CTRL);
  assign status_wr  = wr_hi & (reg_word == `UART_WORD_CTRL);
  assign baud_lo_wr = wr_lo & (reg_word == `UART_WORD_BAUD);
  assign baud_hi_wr = wr_hi & (reg_word == `UART_WORD_BAUD);
  assign data_tx_wr = wr_lo & (reg_word == `UART_WORD_DATA);

  // ====================================================================
  // Registers
  // ====================================================================

  // Only the masked bits are kept
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst)      ctrl <= ctrl_t'(`UART_CTRL_RST);
    else if (ctrl_wr) ctrl <= ctrl_t'(per_din[7:0] & `UART_CTRL_MASK);
  end

  // Divisor halves written independently
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      baud <= `UART_BAUD_RST;
    end else begin
      if (baud_lo_wr) baud[7:0]  <= per_din[7:0];
      if (baud_hi_wr) baud[15:8] <= per_din[15:8];
    end
  end

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst)         data_tx <= `UART_DATA_RST;
    else if (data_tx_wr) data_tx <= per_din[7:0];
  end

  // Received byte lands with the done pulse
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst)          data_rx <= `UART_DATA_RST;
    else if (ctl.rx_done) data_rx <= ctl.rx_data;
  end

  // ====================================================================
  // Pending flags
  // ====================================================================

  // Overrun when a byte arrives on top of an unread one
  assign pnd_set[pnd_rx]       = ctl.rx_done;
  assign pnd_set[pnd_rx_ovflw] = ctl.rx_done & pnd[pnd_rx];
  assign pnd_set[pnd_tx]       = ctl.tx_done;
  assign pnd_set[pnd_tx_empty] = ctl.tx_idle_done;

  // Write 1 to clear, from the STATUS byte lane
  assign pnd_clr = per_din[15:12] & {4{status_wr}};

  // Set beats clear
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) pnd <= 4'b0000;
    else         pnd <= pnd_set | (pnd & ~pnd_clr);
  end

  assign status = '{
    tx_empty_pnd: pnd[pnd_tx_empty],
    tx_pnd:       pnd[pnd_tx],
    rx_ovflw_pnd: pnd[pnd_rx_ovflw],
    rx_pnd:       pnd[pnd_rx],
    tx_full:      ctl.tx_full,
    tx_busy:      ctl.tx_busy,
    zero:         1'b0,
    rx_busy:      ctl.rx_busy
  };

  // ====================================================================
  // Read mux, engine controls and interrupts
  // ====================================================================

  always_comb begin
    per_dout = '0;
    if (reg_rd) begin
      case (reg_word)
        `UART_WORD_CTRL: per_dout = {status, ctrl};
        `UART_WORD_BAUD: per_dout = baud;
        `UART_WORD_DATA: per_dout = {data_rx, data_tx};
        default:         per_dout = '0;
      endcase
    end
  end

  assign ctl.en      = ctrl.en;
  assign ctl.baud    = baud;
  assign ctl.tx_data = data_tx;
  // Trigger pulse for the transmit engine
  assign ctl.tx_load = data_tx_wr;

  assign irq_uart_rx = (pnd[pnd_rx] & ctrl.ien_rx) |
                       (pnd[pnd_rx_ovflw] & ctrl.ien_rx_ovflw);
  // tx_empty_pnd is status only
  assign irq_uart_tx = pnd[pnd_tx] & ctrl.ien_tx;

endmodule

`default_nettype wire

// File: uart_top.sv
// UART peripheral top level
// Register block, RXD filter, receive and transmit engines
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_top (
  input  logic                    mclk,
  input  logic                    puc_rst,
  input  logic [`UART_ADDR_W-1:0] per_addr,
  input  logic [`UART_DATA_W-1:0] per_din,
  input  logic                    per_en,
  input  logic [1:0]              per_we,
  output logic [`UART_DATA_W-1:0] per_dout,
  input  logic                    uart_rxd,
  output logic                    uart_txd,
  output logic                    irq_uart_rx,
  output logic                    irq_uart_tx
);

  // Filtered line and start edge
  logic rxd_s;
  logic rxd_fe;

  uart_ctl_if ctl ();

  uart_regs regs_i (
    .mclk        (mclk),
    .puc_rst     (puc_rst),
    .per_addr    (per_addr),
    .per_din     (per_din),
    .per_en      (per_en),
    .per_we      (per_we),
    .per_dout    (per_dout),
    .ctl         (ctl.regs),
    .irq_uart_rx (irq_uart_rx),
    .irq_uart_tx (irq_uart_tx)
  );

  uart_rx_filter rx_filter_i (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .uart_rxd (uart_rxd),
    .rxd_s    (rxd_s),
    .rxd_fe   (rxd_fe)
  );

  uart_rx rx_i (
    .mclk    (mclk),
    .puc_rst (puc_rst),
    .rxd_s   (rxd_s),
    .rxd_fe  (rxd_fe),
    .ctl     (ctl.rx)
  );

  uart_tx tx_i (
    .mclk     (mclk),
    .puc_rst  (puc_rst),
    .uart_txd (uart_txd),
    .ctl      (ctl.tx)
  );

endmodule

`default_nettype wire

// File: uart_chk.sv
// UART assertion checker, bound to the top level
// Idle line while disabled, TX interrupt source, queued frame start
`timescale 1ns/1ps
`default_nettype none

module uart_chk (
  input logic mclk,
  input logic puc_rst,
  input logic en,
  input logic uart_txd,
  input logic irq_uart_tx,
  input logic ien_tx,
  input logic tx_done,
  input logic tx_full
);

  // Engine resets one edge after en drops
  txd_idle_off: assert property (@(posedge mclk) disable iff (puc_rst) !en |=> uart_txd)
    else $error("uart_txd left idle while the UART is disabled");

  // TX interrupt only after a finished frame or an enable write
  irq_tx_src: assert property (@(posedge mclk) disable iff (puc_rst)
                               $rose(irq_uart_tx) |-> $past(tx_done) || $rose(ien_tx))
    else $error("irq_uart_tx rose without a finished frame");

  // Queued byte starts right after the current frame
  tx_full_next: assert property (@(posedge mclk) disable iff (puc_rst)
                                 $fell(tx_full) && en |=> !uart_txd)
    else $error("queued byte did not start after the frame");

endmodule

bind uart_top uart_chk chk_i (
  .mclk        (mclk),
  .puc_rst     (puc_rst),
  .en          (ctl.en),
  .uart_txd    (uart_txd),
  .irq_uart_tx (irq_uart_tx),
  .ien_tx      (regs_i.ctrl.ien_tx),
  .tx_done     (ctl.tx_done),
  .tx_full     (ctl.tx_full)
);

`default_nettype wire

// File: uart_tb.sv
// UART peripheral testbench
// Clock, reset, bus tasks, serial line models and watchdog
// Random register, transmit, receive, overrun and disable tests
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_tb;

  localparam logic [`UART_ADDR_W-1:0] word_base = 14'(`UART_BASE_ADDR >> 1);
  // Worst case 40 frames of 10 bits at divisor 20, plus margin
  localparam int timeout_cycles = 40 * 10 * 21 + 2000;
  // STATUS bits as seen in the CTRL word
  localparam int st_tx_empty = 15;
  localparam int st_tx_pnd  = 14;
  localparam int st_ovflw   = 13;
  localparam int st_rx_pnd  = 12;
  localparam int st_tx_full = 11;
  localparam int st_tx_busy = 10;

  logic                    mclk;
  logic                    puc_rst;
  logic [`UART_ADDR_W-1:0] per_addr;
  logic [`UART_DATA_W-1:0] per_din;
  logic                    per_en;
  logic [1:0]              per_we;
  logic [`UART_DATA_W-1:0] per_dout;
  logic                    uart_rxd;
  logic                    uart_txd;
  logic                    irq_uart_rx;
  logic                    irq_uart_tx;

  int                      seed = 17152;
  int                      cyc_cnt = 0;
  int                      bit_cycles = 4;

  uart_top dut_i (
    .mclk        (mclk),
    .puc_rst     (puc_rst),
    .per_addr    (per_addr),
    .per_din     (per_din),
    .per_en      (per_en),
    .per_we      (per_we),
    .per_dout    (per_dout),
    .uart_rxd    (uart_rxd),
    .uart_txd    (uart_txd),
    .irq_uart_rx (irq_uart_rx),
    .irq_uart_tx (irq_uart_tx)
  );

  initial begin
    mclk = 1'b0;
    forever #4 mclk = ~mclk;
  end

  // Watchdog
  always @(posedge mclk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= timeout_cycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
      $display("Regression failed");
      $fatal(1, "Watchdog expired");
    end
  end

  // ====================================================================
  // Helpers
  // ====================================================================

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic [`UART_ADDR_W-1:0] word_addr(input logic [1:0] word);
    return word_base + 14'(word);
  endfunction

  task automatic check_eq(input string name, input logic [15:0] got,
                          input logic [15:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("Regression failed");
      $fatal(1, "Value mismatch");
    end
  endtask

  // One-cycle access, write lands on the second edge
  task automatic bus_write(input logic [`UART_ADDR_W-1:0] addr, input logic [1:0] we,
                           input logic [15:0] din);
    @(posedge mclk);
    per_en   <= 1'b1;
    per_we   <= we;
    per_addr <= addr;
    per_din  <= din;
    @(posedge mclk);
    per_en <= 1'b0;
    per_we <= 2'b00;
  endtask

  // Read data sampled mid-cycle
  task automatic bus_read(input logic [`UART_ADDR_W-1:0] addr, output logic [15:0] dout);
    @(posedge mclk);
    per_en   <= 1'b1;
    per_we   <= 2'b00;
    per_addr <= addr;
    @(negedge mclk);
    dout = per_dout;
    @(posedge mclk);
    per_en <= 1'b0;
  endtask

  // Random divisor in 3..20
  task automatic set_baud();
    logic [15:0] baud_val;
    baud_val   = 16'(32'd3 + (rand_word() % 32'd18));
    bit_cycles = int'(baud_val) + 1;
    bus_write(word_addr(`UART_WORD_BAUD), 2'b11, baud_val);
  endtask

  task automatic clear_flags();
    bus_write(word_addr(`UART_WORD_CTRL), 2'b10, 16'hf000);
  endtask

  // Poll STATUS until a pending flag sets
  task automatic wait_flag(input int idx, input string name);
    logic [15:0] d;
    int          polls;
    polls = 0;
    bus_read(word_addr(`UART_WORD_CTRL), d);
    while (!d[idx] && polls < 200) begin
      polls++;
      bus_read(word_addr(`UART_WORD_CTRL), d);
    end
    if (!d[idx]) begin
      $display("STATUS flag %s never became set", name);
      $display("Regression failed");
      $fatal(1, "Pending flag timeout");
    end
  endtask

  // ====================================================================
  // Serial line models
  // ====================================================================

  task automatic send_bit(input logic b);
    uart_rxd <= b;
    repeat (bit_cycles) @(posedge mclk);
  endtask

  // Start, 8 data bits LSB first, stop
  task automatic send_frame(input logic [7:0] data);
    @(posedge mclk);
    send_bit(1'b0);
    for (int i = 0; i < 8; i++) send_bit(data[i]);
    send_bit(1'b1);
  endtask

  task automatic wait_start();
    @(negedge mclk);
    while (uart_txd !== 1'b0) @(negedge mclk);
  endtask

  // Samples near the middle of each bit
  task automatic capture_frame(output logic [7:0] data);
    wait_start();
    repeat (bit_cycles / 2) @(negedge mclk);
    check_eq("uart_txd start bit", 16'(uart_txd), 16'h0);
    for (int i = 0; i < 8; i++) begin
      repeat (bit_cycles) @(negedge mclk);
      data[i] = uart_txd;
    end
    repeat (bit_cycles) @(negedge mclk);
    check_eq("uart_txd stop bit", 16'(uart_txd), 16'h1);
  endtask

  // ====================================================================
  // Test sequence
  // ====================================================================

  initial begin
    logic [31:0] r;
    logic [15:0] d;
    logic [1:0]  word;
    logic [1:0]  we;
    logic [15:0] din;
    logic [7:0]  ctrl_m;
    logic [15:0] baud_m;
    logic [7:0]  data_tx_m;
    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  got_a;
    logic [7:0]  got_b;
    logic [`UART_ADDR_W-1:0] addr;
    logic        ien;

    puc_rst  = 1'b1;
    per_addr = '0;
    per_din  = '0;
    per_en   = 1'b0;
    per_we   = 2'b00;
    uart_rxd = 1'b1;
    ctrl_m    = 8'h00;
    baud_m    = 16'h0000;
    data_tx_m = 8'h00;
    repeat (8) @(posedge mclk);
    puc_rst <= 1'b0;

    // Register access with the engines disabled
    for (int i = 0; i < 24; i++) begin
      r    = rand_word();
      word = r[1:0] % 2'd3;
      we   = (r[3:2] == 2'b00) ? 2'b11 : r[3:2];
      din  = r[31:16];
      if (word == `UART_WORD_CTRL) din[0] = 1'b0;
      if (word == `UART_WORD_CTRL && we[0]) ctrl_m = din[7:0] & `UART_CTRL_MASK;
      if (word == `UART_WORD_BAUD && we[0]) baud_m[7:0] = din[7:0];
      if (word == `UART_WORD_BAUD && we[1]) baud_m[15:8] = din[15:8];
      if (word == `UART_WORD_DATA && we[0]) data_tx_m = din[7:0];
      bus_write(word_addr(word), we, din);
      bus_read(word_addr(word), d);
      case (word)
        `UART_WORD_CTRL: check_eq("CTRL", 16'(d[7:0]), 16'(ctrl_m));
        `UART_WORD_BAUD: check_eq("BAUD", d, baud_m);
        default:         check_eq("DATA", d, {8'h00, data_tx_m});
      endcase
    end
    data_tx_m = rand_word() & 8'hff;
    bus_write(word_addr(`UART_WORD_DATA), 2'b01, {8'h00, data_tx_m});
    for (int i = 0; i < 4; i++) begin
      addr = 14'(rand_word());
      if (addr[13:2] == word_base[13:2]) addr[13] = ~addr[13];
      bus_read(addr, d);
      check_eq("per_dout unselected", d, 16'h0000);
    end
    bus_read(word_addr(2'd3), d);
    check_eq("per_dout word 3", d, 16'h0000);

    // Enabling sends the byte still held by the trigger
    set_baud();
    fork
      bus_write(word_addr(`UART_WORD_CTRL), 2'b01, 16'h0001);
      capture_frame(got_a);
    join
    check_eq("uart_txd held byte", 16'(got_a), 16'(data_tx_m));
    wait_flag(st_tx_pnd, "tx_pnd");
    clear_flags();

    // Single-byte transmit
    for (int i = 0; i < 6; i++) begin
      r   = rand_word();
      ien = r[8];
      a   = r[7:0];
      bus_write(word_addr(`UART_WORD_CTRL), 2'b01, {9'h000, ien, 6'h01});
      fork
        bus_write(word_addr(`UART_WORD_DATA), 2'b01, {8'h00, a});
        capture_frame(got_a);
      join
      check_eq("uart_txd data", 16'(got_a), 16'(a));
      wait_flag(st_tx_pnd, "tx_pnd");
      bus_read(word_addr(`UART_WORD_CTRL), d);
      check_eq("STATUS pending", 16'(d[15:12]), 16'hc);
      check_eq("irq_uart_tx", 16'(irq_uart_tx), 16'(ien));
      clear_flags();
      @(negedge mclk);
      check_eq("irq_uart_tx cleared", 16'(irq_uart_tx), 16'h0);
    end

    // Back-to-back transmit
    set_baud();
    bus_write(word_addr(`UART_WORD_CTRL), 2'b01, 16'h0001);
    for (int i = 0; i < 4; i++) begin
      r = rand_word();
      a = r[7:0];
      b = r[15:8];
      fork
        begin
          bus_write(word_addr(`UART_WORD_DATA), 2'b01, {8'h00, a});
          repeat (2 * bit_cycles) @(posedge mclk);
          bus_write(word_addr(`UART_WORD_DATA), 2'b01, {8'h00, b});
          bus_read(word_addr(`UART_WORD_CTRL), d);
          check_eq("tx_full", 16'(d[st_tx_full]), 16'h1);
        end
        begin
          capture_frame(got_a);
          capture_frame(got_b);
        end
      join
      check_eq("uart_txd first byte", 16'(got_a), 16'(a));
      check_eq("uart_txd second byte", 16'(got_b), 16'(b));
      // tx_pnd is already set by the first frame
      wait_flag(st_tx_empty, "tx_empty_pnd");
      bus_read(word_addr(`UART_WORD_CTRL), d);
      check_eq("STATUS pending", 16'(d[15:12]), 16'hc);
      clear_flags();
    end

    // Receive with write-1 clear
    set_baud();
    for (int i = 0; i < 6; i++) begin
      r   = rand_word();
      ien = r[8];
      a   = r[7:0];
      bus_write(word_addr(`UART_WORD_CTRL), 2'b01, {11'h000, ien, 4'h1});
      send_frame(a);
      wait_flag(st_rx_pnd, "rx_pnd");
      bus_read(word_addr(`UART_WORD_CTRL), d);
      check_eq("STATUS pending", 16'(d[15:12]), 16'h1);
      bus_read(word_addr(`UART_WORD_DATA), d);
      check_eq("DATA_RX", 16'(d[15:8]), 16'(a));
      check_eq("irq_uart_rx", 16'(irq_uart_rx), 16'(ien));
      bus_write(word_addr(`UART_WORD_CTRL), 2'b10, 16'h1000);
      bus_read(word_addr(`UART_WORD_CTRL), d);
      check_eq("rx_pnd cleared", 16'(d[st_rx_pnd]), 16'h0);
      check_eq("irq_uart_rx cleared", 16'(irq_uart_rx), 16'h0);
    end

    // Overrun, second byte overwrites the first
    bus_write(word_addr(`UART_WORD_CTRL), 2'b01, 16'h0021);
    for (int i = 0; i < 2; i++) begin
      r = rand_word();
      a = r[7:0];
      b = r[15:8];
      send_frame(a);
      wait_flag(st_rx_pnd, "rx_pnd");
      check_eq("irq_uart_rx before overrun", 16'(irq_uart_rx), 16'h0);
      send_frame(b);
      wait_flag(st_ovflw, "rx_ovflw_pnd");
      bus_read(word_addr(`UART_WORD_DATA), d);
      check_eq("DATA_RX after overrun", 16'(d[15:8]), 16'(b));
      check_eq("irq_uart_rx overrun", 16'(irq_uart_rx), 16'h1);
      clear_flags();
      @(negedge mclk);
      check_eq("irq_uart_rx cleared", 16'(irq_uart_rx), 16'h0);
    end

    // Disable in mid-frame at the slowest divisor
    bit_cycles = 21;
    bus_write(word_addr(`UART_WORD_BAUD), 2'b11, 16'd20);
    bus_write(word_addr(`UART_WORD_CTRL), 2'b01, 16'h0001);
    bus_write(word_addr(`UART_WORD_DATA), 2'b01, 16'h0000);
    wait_start();
    repeat (3 * bit_cycles) @(posedge mclk);
    bus_write(word_addr(`UART_WORD_CTRL), 2'b01, 16'h0000);
    @(posedge mclk);
    @(negedge mclk);
    check_eq("uart_txd disabled", 16'(uart_txd), 16'h1);
    bus_read(word_addr(`UART_WORD_CTRL), d);
    check_eq("tx_busy disabled", 16'(d[st_tx_busy]), 16'h0);
    repeat (2 * bit_cycles) @(negedge mclk);
    check_eq("uart_txd stays idle", 16'(uart_txd), 16'h1);

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: uart.f
+incdir+.
uart_pkg.sv
uart_ctl_if.sv
uart_rx_filter.sv
uart_rx.sv
uart_tx.sv
uart_regs.sv
uart_top.sv
uart_chk.sv
uart_tb.sv

// File: run.sh
#!/bin/sh
# Build the UART testbench with Verilator, run it and scan the log
verilator --binary --timing --assert --top-module uart_tb -f uart.f -o uart_sim \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
{ ./obj_dir/uart_sim > sim.log 2>&1 || echo "Regression failed" >> sim.log; } &&
  cat sim.log &&
  ! grep -q "Regression failed" sim.log && exit 0 || exit 1
